/* rs_defines.svh */
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// operand and result width of the alu lanes
`define RS_DATA_W 32

// rob tag width, one tag per micro-op in flight
`define RS_TAG_W 5

// alu lanes, one reservation station behind each
`define RS_NUM_LANES 2

// entries held by a single station
`define RS_DEPTH 4

`endif

/* src/rs_pkg.sv */
`include "rs_defines.svh"

package rs_pkg;

  typedef logic [`RS_DATA_W-1:0] data_t;
  typedef logic [`RS_TAG_W-1:0] tag_t;
  // free-slot count, needs to reach RS_DEPTH itself
  typedef logic [$clog2(`RS_DEPTH+1)-1:0] count_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_orr,
    alu_eor,
    alu_mov
  } alu_op_t;

  typedef enum logic [$clog2(`RS_NUM_LANES)-1:0] {
    lane0,
    lane1
  } lane_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // either a ready value or the tag of its producer
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t value;
  } rs_operand_t;

  typedef struct packed {
    alu_op_t     op;
    lane_t       lane;
    tag_t        dst_tag;
    logic        set_nzcv;
    rs_operand_t src_a;
    rs_operand_t src_b;
  } rs_uop_t;

  typedef struct packed {
    logic    entry_valid;
    rs_uop_t uop;
  } rs_entry_t;

  typedef struct packed {
    alu_op_t op;
    tag_t    dst_tag;
    logic    set_nzcv;
    data_t   val_a;
    data_t   val_b;
  } rs_issue_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t value;
    logic  set_nzcv;
    nzcv_t nzcv;
  } cdb_t;

  // capture a broadcast value into a waiting operand
  function automatic rs_operand_t wake_operand(rs_operand_t op, cdb_t cdb);
    rs_operand_t res;
    res = op;
    if (!op.valid && cdb.valid && (op.tag == cdb.tag)) begin
      res.valid = 1'b1;
      res.value = cdb.value;
    end
    return res;
  endfunction

  // both sources of a micro-op against the same broadcast
  function automatic rs_uop_t wake_uop(rs_uop_t uop, cdb_t cdb);
    rs_uop_t res;
    res = uop;
    res.src_a = wake_operand(uop.src_a, cdb);
    res.src_b = wake_operand(uop.src_b, cdb);
    return res;
  endfunction

endpackage

/* src/dispatch_router.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module dispatch_router (
  input  logic                                in_clk,
  input  logic                                in_rst,
  input  logic                                in_dispatch_valid,
  input  rs_pkg::rs_uop_t                     in_dispatch,
  input  rs_pkg::cdb_t                        in_cdb,
  input  rs_pkg::count_t [`RS_NUM_LANES-1:0]  in_lane_free_count,
  output logic [`RS_NUM_LANES-1:0]            out_wr,
  output rs_pkg::rs_uop_t                     out_wr_uop,
  output logic [`RS_NUM_LANES-1:0]            out_lane_full
);
  import rs_pkg::*;

  logic    held_valid;
  rs_uop_t held_uop;

  // one-deep holding stage, refilled on every strobe
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      held_valid <= 1'b0;
    end else begin
      held_valid <= in_dispatch_valid;
    end
  end

  // sources matching this cycle's broadcast are filled on capture,
  // otherwise that result would pass before the station sees the entry
  always_ff @(posedge in_clk) begin
    if (in_dispatch_valid) begin
      held_uop <= wake_uop(in_dispatch, in_cdb);
    end
  end

  assign out_wr_uop = held_uop;

  always_comb begin
    for (int i = 0; i < `RS_NUM_LANES; i++) begin
      // lane field decoded into a one-hot write pulse
      out_wr[i] = held_valid && (held_uop.lane == lane_t'(i));
      // the held micro-op already owns one of the free slots
      out_lane_full[i] = in_lane_free_count[i] <= count_t'(out_wr[i]);
    end
  end

  // the full level is only correct if the source respects it
  a_no_dispatch_to_full_lane : assert property (
    @(posedge in_clk) disable iff (in_rst)
    in_dispatch_valid |-> !out_lane_full[in_dispatch.lane]
  ) else $error("dispatch strobe to full lane %0d", in_dispatch.lane);

endmodule

/* src/reservation_station.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module reservation_station (
  input  logic              in_clk,
  input  logic              in_rst,
  input  logic              in_wr,
  input  rs_pkg::rs_uop_t   in_wr_uop,
  input  rs_pkg::cdb_t      in_cdb,
  input  logic              in_grant,
  output rs_pkg::count_t    out_free_count,
  output logic              out_issue_valid,
  output rs_pkg::rs_issue_t out_issue
);
  import rs_pkg::*;

  localparam int idx_w = (`RS_DEPTH > 1) ? $clog2(`RS_DEPTH) : 1;

  rs_entry_t [`RS_DEPTH-1:0] entries;

  // slot currently parked in the issue register
  logic [idx_w-1:0] issue_idx;

  logic [`RS_DEPTH-1:0] free_vec;
  logic [`RS_DEPTH-1:0] ready_vec;
  logic                 free_found;
  logic [idx_w-1:0]     free_idx;
  logic                 ready_found;
  logic [idx_w-1:0]     ready_idx;
  logic                 issue_load;
  count_t               free_count;
  rs_uop_t              wr_uop;

  always_comb begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      free_vec[i] = !entries[i].entry_valid;
      // both operands present and not already offered to the arbiter
      ready_vec[i] = entries[i].entry_valid &&
                     entries[i].uop.src_a.valid &&
                     entries[i].uop.src_b.valid &&
                     !(out_issue_valid && (issue_idx == idx_w'(i)));
    end
  end

  // lowest free slot, scanned top-down so the lowest match wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = `RS_DEPTH-1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_found = 1'b1;
        free_idx   = idx_w'(i);
      end
    end
  end

  // lowest ready slot, same scan
  always_comb begin
    ready_found = 1'b0;
    ready_idx   = '0;
    for (int i = `RS_DEPTH-1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        ready_found = 1'b1;
        ready_idx   = idx_w'(i);
      end
    end
  end

  always_comb begin
    free_count = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      free_count = free_count + count_t'(free_vec[i]);
    end
  end

  assign out_free_count = free_count;

  // a result on the bus in the write cycle would otherwise be missed
  assign wr_uop = wake_uop(in_wr_uop, in_cdb);

  // issue register is open when empty or being granted this edge
  assign issue_load = !out_issue_valid || in_grant;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        entries[i].entry_valid <= 1'b0;
      end
      out_issue_valid <= 1'b0;
    end else begin
      // tag wakeup across all occupied slots
      for (int i = 0; i < `RS_DEPTH; i++) begin
        if (entries[i].entry_valid) begin
          entries[i].uop <= wake_uop(entries[i].uop, in_cdb);
        end
      end
      // slot is released only once the arbiter has taken it
      if (in_grant && out_issue_valid) begin
        entries[issue_idx].entry_valid <= 1'b0;
      end
      // the free slot can never be the issuing one, so no clash here
      if (in_wr && free_found) begin
        entries[free_idx].entry_valid <= 1'b1;
        entries[free_idx].uop         <= wr_uop;
      end
      if (issue_load) begin
        out_issue_valid <= ready_found;
      end
    end
  end

  // issue payload, ready entries no longer change so a copy is safe
  always_ff @(posedge in_clk) begin
    if (issue_load && ready_found) begin
      issue_idx          <= ready_idx;
      out_issue.op       <= entries[ready_idx].uop.op;
      out_issue.dst_tag  <= entries[ready_idx].uop.dst_tag;
      out_issue.set_nzcv <= entries[ready_idx].uop.set_nzcv;
      out_issue.val_a    <= entries[ready_idx].uop.src_a.value;
      out_issue.val_b    <= entries[ready_idx].uop.src_b.value;
    end
  end

  // router full level must keep writes away from a packed station
  a_wr_has_slot : assert property (
    @(posedge in_clk) disable iff (in_rst)
    in_wr |-> free_found
  ) else $error("write into station with no free slot");

  // arbiter may only grant what is being offered
  a_grant_when_valid : assert property (
    @(posedge in_clk) disable iff (in_rst)
    in_grant |-> out_issue_valid
  ) else $error("grant without issue_valid");

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module cdb_arbiter (
  input  logic                                  in_clk,
  input  logic                                  in_rst,
  input  logic [`RS_NUM_LANES-1:0]              in_issue_valid,
  input  rs_pkg::rs_issue_t [`RS_NUM_LANES-1:0] in_issue,
  output logic [`RS_NUM_LANES-1:0]              out_grant,
  output rs_pkg::cdb_t                          out_cdb
);
  import rs_pkg::*;

  localparam int msb = `RS_DATA_W - 1;

  lane_t     last_lane;
  lane_t     grant_lane;
  logic      grant_any;
  rs_issue_t sel;
  data_t     result;
  logic      carry;
  logic      ovf;
  nzcv_t     flags;

  // rotating priority, the lane after the last winner goes first
  always_comb begin
    out_grant  = '0;
    grant_any  = 1'b0;
    grant_lane = last_lane;
    // walk from farthest to nearest so the nearest valid lane sticks
    for (int k = `RS_NUM_LANES; k >= 1; k--) begin
      int idx;
      idx = (int'(last_lane) + k) % `RS_NUM_LANES;
      if (in_issue_valid[idx]) begin
        grant_any  = 1'b1;
        grant_lane = lane_t'(idx);
      end
    end
    if (grant_any) begin
      out_grant[grant_lane] = 1'b1;
    end
  end

  assign sel = in_issue[grant_lane];

  always_comb begin
    logic [`RS_DATA_W:0] wide;
    wide   = '0;
    result = '0;
    carry  = 1'b0;
    ovf    = 1'b0;
    case (sel.op)
      alu_add: begin
        wide   = {1'b0, sel.val_a} + {1'b0, sel.val_b};
        result = wide[msb:0];
        carry  = wide[`RS_DATA_W];
        ovf    = (sel.val_a[msb] == sel.val_b[msb]) && (result[msb] != sel.val_a[msb]);
      end
      alu_sub: begin
        // a + ~b + 1, carry out high means no borrow
        wide   = {1'b0, sel.val_a} + {1'b0, ~sel.val_b} + 1'b1;
        result = wide[msb:0];
        carry  = wide[`RS_DATA_W];
        ovf    = (sel.val_a[msb] != sel.val_b[msb]) && (result[msb] != sel.val_a[msb]);
      end
      alu_and: result = sel.val_a & sel.val_b;
      alu_orr: result = sel.val_a | sel.val_b;
      alu_eor: result = sel.val_a ^ sel.val_b;
      alu_mov: result = sel.val_b;
      default: result = '0;
    endcase
    flags.n = result[msb];
    flags.z = (result == '0);
    flags.c = carry;
    flags.v = ovf;
    // flags only reported for micro-ops that ask for them
    if (!sel.set_nzcv) begin
      flags = '0;
    end
  end

  // result lands on the bus at the grant edge, valid for one cycle
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      out_cdb.valid <= 1'b0;
      last_lane     <= lane0;
    end else begin
      out_cdb.valid <= grant_any;
      if (grant_any) begin
        last_lane        <= grant_lane;
        out_cdb.tag      <= sel.dst_tag;
        out_cdb.value    <= result;
        out_cdb.set_nzcv <= sel.set_nzcv;
        out_cdb.nzcv     <= flags;
      end
    end
  end

  // a lane passed over is served before every other lane gets a second turn
  for (genvar i = 0; i < `RS_NUM_LANES; i++) begin : g_wait_check
    a_grant_wait_bound : assert property (
      @(posedge in_clk) disable iff (in_rst)
      (in_issue_valid[i] && !out_grant[i]) |-> ##[1:`RS_NUM_LANES-1] out_grant[i]
    ) else $error("lane %0d waited more than %0d cycles for a grant", i, `RS_NUM_LANES - 1);
  end

endmodule

/* src/rs_cluster.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_cluster (
  input  logic                     in_clk,
  input  logic                     in_rst,
  input  logic                     in_dispatch_valid,
  input  rs_pkg::rs_uop_t          in_dispatch,
  output logic [`RS_NUM_LANES-1:0] out_lane_full,
  output rs_pkg::cdb_t             out_cdb
);
  import rs_pkg::*;

  // router to stations
  logic [`RS_NUM_LANES-1:0] lane_wr;
  rs_uop_t                  wr_uop;
  count_t [`RS_NUM_LANES-1:0] free_count;

  // stations to arbiter and back
  logic [`RS_NUM_LANES-1:0]      issue_valid;
  rs_issue_t [`RS_NUM_LANES-1:0] issue;
  logic [`RS_NUM_LANES-1:0]      grant;

  dispatch_router u_router (
    .in_clk             (in_clk),
    .in_rst             (in_rst),
    .in_dispatch_valid  (in_dispatch_valid),
    .in_dispatch        (in_dispatch),
    .in_cdb             (out_cdb),
    .in_lane_free_count (free_count),
    .out_wr             (lane_wr),
    .out_wr_uop         (wr_uop),
    .out_lane_full      (out_lane_full)
  );

  // one station per alu lane, all snooping the same broadcast
  for (genvar g = 0; g < `RS_NUM_LANES; g++) begin : g_lane
    reservation_station u_station (
      .in_clk          (in_clk),
      .in_rst          (in_rst),
      .in_wr           (lane_wr[g]),
      .in_wr_uop       (wr_uop),
      .in_cdb          (out_cdb),
      .in_grant        (grant[g]),
      .out_free_count  (free_count[g]),
      .out_issue_valid (issue_valid[g]),
      .out_issue       (issue[g])
    );
  end

  // broadcast also leaves the cluster as the rob writeback
  cdb_arbiter u_arbiter (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .in_issue_valid (issue_valid),
    .in_issue       (issue),
    .out_grant      (grant),
    .out_cdb        (out_cdb)
  );

endmodule

/* test/tb_rs_cluster.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module tb_rs_cluster;
  import rs_pkg::*;

  // 18 + 8 + 10 + 200 micro-ops over the five tests
  localparam int total_uops = 236;
  localparam int cycle_limit = 64 * total_uops + 200;
  localparam int num_tags = 1 << `RS_TAG_W;
  localparam int msb = `RS_DATA_W - 1;

  logic                     in_clk;
  logic                     in_rst;
  logic                     in_dispatch_valid;
  rs_uop_t                  in_dispatch;
  logic [`RS_NUM_LANES-1:0] out_lane_full;
  cdb_t                     out_cdb;

  integer seed = 32'hfac0b992;

  // scoreboard indexed by destination tag
  data_t exp_value [num_tags];
  nzcv_t exp_nzcv [num_tags];
  logic  exp_set [num_tags];
  logic  pending [num_tags];
  int    next_tag = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    cycle_count = 0;

  rs_cluster u_rs_cluster (
    .in_clk            (in_clk),
    .in_rst            (in_rst),
    .in_dispatch_valid (in_dispatch_valid),
    .in_dispatch       (in_dispatch),
    .out_lane_full     (out_lane_full),
    .out_cdb           (out_cdb)
  );

  initial begin
    in_clk = 1'b0;
    forever #20 in_clk = ~in_clk;
  end

  // alu rule: carry and overflow from widened sums, n and z from the result
  function automatic void alu_ref(input alu_op_t op, input data_t a, input data_t b,
                                  input logic set_nzcv, output data_t res,
                                  output nzcv_t flags);
    logic [`RS_DATA_W:0]        wide_u;
    logic signed [`RS_DATA_W:0] wide_s;
    res   = '0;
    flags = '0;
    case (op)
      alu_add: begin
        wide_u  = {1'b0, a} + {1'b0, b};
        wide_s  = {a[msb], a} + {b[msb], b};
        res     = wide_u[msb:0];
        flags.c = wide_u[`RS_DATA_W];
        flags.v = wide_s[`RS_DATA_W] != wide_s[msb];
      end
      alu_sub: begin
        wide_s  = {a[msb], a} - {b[msb], b};
        res     = a - b;
        // no borrow
        flags.c = (a >= b);
        flags.v = wide_s[`RS_DATA_W] != wide_s[msb];
      end
      alu_and: res = a & b;
      alu_orr: res = a | b;
      alu_eor: res = a ^ b;
      alu_mov: res = b;
      default: res = '0;
    endcase
    flags.n = res[msb];
    flags.z = (res == '0);
    if (!set_nzcv) begin
      flags = '0;
    end
  endfunction

  function automatic int count_pending();
    int n;
    n = 0;
    for (int t = 0; t < num_tags; t++) begin
      n += pending[t];
    end
    return n;
  endfunction

  // producer still in flight goes out as a tag, else as its known value
  function automatic rs_operand_t make_operand(input logic dep, input int tag, input data_t val);
    rs_operand_t opnd;
    opnd.valid = 1'b1;
    opnd.tag   = '0;
    opnd.value = dep ? exp_value[tag] : val;
    if (dep && pending[tag]) begin
      opnd.valid = 1'b0;
      opnd.tag   = tag_t'(tag);
      // junk that a missed wakeup would leak into the result
      opnd.value = ~exp_value[tag];
    end
    return opnd;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge in_clk);
      #2;
    end
  endtask

  // next tag not in flight, rotating so tags are reused late
  task automatic get_tag(output int tag);
    tag = -1;
    while (tag < 0) begin
      for (int k = 0; k < num_tags && tag < 0; k++) begin
        if (!pending[(next_tag + k) % num_tags]) begin
          tag = (next_tag + k) % num_tags;
        end
      end
      if (tag < 0) begin
        idle(1);
      end
    end
    next_tag = (tag + 1) % num_tags;
  endtask

  task automatic dispatch_uop(input lane_t lane, input alu_op_t op, input logic set_nzcv,
                              input logic a_dep, input int a_tag, input data_t a_val,
                              input logic b_dep, input int b_tag, input data_t b_val,
                              output int dst);
    rs_uop_t uop;
    data_t   res;
    nzcv_t   flags;
    // hold off while the target station has no room
    while (out_lane_full[lane]) begin
      idle(1);
    end
    get_tag(dst);
    uop.op       = op;
    uop.lane     = lane;
    uop.dst_tag  = tag_t'(dst);
    uop.set_nzcv = set_nzcv;
    uop.src_a    = make_operand(a_dep, a_tag, a_val);
    uop.src_b    = make_operand(b_dep, b_tag, b_val);
    alu_ref(op, a_dep ? exp_value[a_tag] : a_val, b_dep ? exp_value[b_tag] : b_val,
            set_nzcv, res, flags);
    exp_value[dst] = res;
    exp_nzcv[dst]  = flags;
    exp_set[dst]   = set_nzcv;
    pending[dst]   = 1'b1;
    in_dispatch       = uop;
    in_dispatch_valid = 1'b1;
    idle(1);
    in_dispatch_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (count_pending() != 0) begin
      idle(1);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: done, %0d errors", num, name, fail_count - errs_before);
  endtask

  task automatic run_reset_check();
    int errs;
    errs = fail_count;
    for (int i = 0; i < 3; i++) begin
      if (out_cdb.valid !== 1'b0) begin
        $display("MISMATCH time=%0t signal=out_cdb.valid got=%b exp=0", $time, out_cdb.valid);
        fail_count++;
      end
      if (out_lane_full !== '0) begin
        $display("MISMATCH time=%0t signal=out_lane_full got=%b exp=%b", $time,
                 out_lane_full, {`RS_NUM_LANES{1'b0}});
        fail_count++;
      end
      idle(1);
    end
    report_test(1, "reset state", errs);
  endtask

  task automatic run_independent();
    int      errs;
    int      dst;
    data_t   a;
    data_t   b;
    alu_op_t op;
    errs = fail_count;
    // per opcode: corner pair flags off, corner pair flags on, random pair
    for (int i = 0; i < 18; i++) begin
      op = alu_op_t'(i / 3);
      case (op)
        alu_add: {a, b} = {32'h7fff_ffff, 32'h0000_0001};
        alu_sub: {a, b} = {32'h8000_0000, 32'h0000_0001};
        alu_and: {a, b} = {32'hf0f0_f0f0, 32'h0f0f_0f0f};
        alu_orr: {a, b} = {32'h0000_0000, 32'h0000_0000};
        alu_eor: {a, b} = {32'haaaa_aaaa, 32'h5555_5555};
        default: {a, b} = {32'h0000_1234, 32'h8000_0000};
      endcase
      if (i % 3 == 2) begin
        a = $random(seed);
        b = $random(seed);
      end
      dispatch_uop(lane_t'(i % 2), op, i % 3 != 0, 1'b0, 0, a, 1'b0, 0, b, dst);
    end
    wait_drain();
    report_test(2, "independent ops", errs);
  endtask

  task automatic run_chain();
    int errs;
    int prev;
    int prev2;
    int dst;
    errs  = fail_count;
    prev  = 0;
    prev2 = 0;
    // each link reads the two links before it, lanes alternate
    for (int i = 0; i < 4; i++) begin
      dispatch_uop(lane_t'(i % 2), alu_op_t'(i), 1'b1, i > 0, prev, $random(seed),
                   i > 1, prev2, $random(seed), dst);
      prev2 = prev;
      prev  = dst;
    end
    wait_drain();
    // with gap 2 the producer result is on the bus while the router holds the consumer
    // with gap 3 it is on the bus in the dispatch cycle
    for (int gap = 2; gap <= 3; gap++) begin
      dispatch_uop(lane0, alu_add, 1'b1, 1'b0, 0, $random(seed), 1'b0, 0, $random(seed), prev);
      idle(gap);
      dispatch_uop(lane1, alu_sub, 1'b1, 1'b1, prev, '0, 1'b0, 0, $random(seed), dst);
      wait_drain();
    end
    report_test(3, "dependency chain", errs);
  endtask

  task automatic run_full_lane();
    int errs;
    int prev;
    int dst;
    errs = fail_count;
    prev = 0;
    // slow producer chain in lane 1
    for (int i = 0; i < 4; i++) begin
      dispatch_uop(lane1, alu_add, 1'b0, i > 0, prev, $random(seed), 1'b0, 0, 32'h1, dst);
      prev = dst;
    end
    for (int i = 0; i < `RS_DEPTH; i++) begin
      dispatch_uop(lane0, alu_eor, 1'b1, 1'b1, prev, '0, 1'b0, 0, $random(seed), dst);
    end
    if (out_lane_full[0] !== 1'b1) begin
      $display("%0t: lane 0 not reported full while holding %0d blocked micro-ops",
               $time, `RS_DEPTH);
      fail_count++;
    end
    // these wait until the blocked entries drain
    for (int i = 0; i < 2; i++) begin
      dispatch_uop(lane0, alu_orr, 1'b1, 1'b0, 0, $random(seed), 1'b0, 0, $random(seed), dst);
    end
    wait_drain();
    report_test(4, "full lane", errs);
  endtask

  task automatic run_random();
    int   errs;
    int   dst;
    int   recent [4];
    logic a_dep;
    logic b_dep;
    errs = fail_count;
    for (int i = 0; i < 200; i++) begin
      // dependencies only once four recent tags exist
      a_dep = (i >= 4) && ($unsigned($random(seed)) % 2 == 0);
      b_dep = (i >= 4) && ($unsigned($random(seed)) % 3 == 0);
      dispatch_uop(lane_t'($unsigned($random(seed)) % `RS_NUM_LANES),
                   alu_op_t'($unsigned($random(seed)) % 6), logic'($random(seed) & 1),
                   a_dep, recent[$unsigned($random(seed)) % 4], $random(seed),
                   b_dep, recent[$unsigned($random(seed)) % 4], $random(seed), dst);
      recent[i % 4] = dst;
      if ($unsigned($random(seed)) % 8 == 0) begin
        idle(1);
      end
    end
    wait_drain();
    report_test(5, "random mix", errs);
  endtask

  // compare every broadcast away from the edge that launched it
  always @(negedge in_clk) begin
    if (!in_rst && out_cdb.valid) begin
      if (!pending[out_cdb.tag]) begin
        $display("%0t: broadcast of tag %0d that has no micro-op in flight, duplicate or unknown",
                 $time, out_cdb.tag);
        fail_count++;
      end else if (out_cdb.value !== exp_value[out_cdb.tag]) begin
        $display("MISMATCH time=%0t signal=out_cdb.value tag=%0d got=%h exp=%h", $time,
                 out_cdb.tag, out_cdb.value, exp_value[out_cdb.tag]);
        fail_count++;
      end else if (out_cdb.nzcv !== exp_nzcv[out_cdb.tag]) begin
        $display("MISMATCH time=%0t signal=out_cdb.nzcv tag=%0d got=%b exp=%b", $time,
                 out_cdb.tag, out_cdb.nzcv, exp_nzcv[out_cdb.tag]);
        fail_count++;
      end else if (out_cdb.set_nzcv !== exp_set[out_cdb.tag]) begin
        $display("MISMATCH time=%0t signal=out_cdb.set_nzcv tag=%0d got=%b exp=%b", $time,
                 out_cdb.tag, out_cdb.set_nzcv, exp_set[out_cdb.tag]);
        fail_count++;
      end else begin
        pass_count++;
      end
      pending[out_cdb.tag] = 1'b0;
    end
  end

  always @(posedge in_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, %0d micro-ops never broadcast",
               cycle_count, count_pending());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    in_rst            = 1'b1;
    in_dispatch_valid = 1'b0;
    in_dispatch       = '0;
    for (int t = 0; t < num_tags; t++) begin
      pending[t] = 1'b0;
    end
    repeat (16) @(posedge in_clk);
    #2;
    in_rst = 1'b0;
    run_reset_check();
    run_independent();
    run_chain();
    run_full_lane();
    run_random();
    $display("summary: %0d checks passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
src/rs_pkg.sv
src/dispatch_router.sv
src/reservation_station.sv
src/cdb_arbiter.sv
src/rs_cluster.sv
test/tb_rs_cluster.sv

/* Bender.yml */
package:
  name: rs_cluster

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - src/rs_pkg.sv
      - src/dispatch_router.sv
      - src/reservation_station.sv
      - src/cdb_arbiter.sv
      - src/rs_cluster.sv
      - target: test
        files:
          - test/tb_rs_cluster.sv
